// File: Bender.yml
package:
  name: mos_core

sources:
  - mos_isa_pkg.sv
  - mos_core_pkg.sv
  - mos_alu.sv
  - mos_decoder.sv
  - mos_sequencer.sv
  - mos_core.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_mos_core.sv

// File: mos_alu.sv
/* Combinational shift, rotate, increment and decrement unit
   Only the carry flag is produced; INC and DEC pass carry_in through */
`timescale 1ns/1ps
`default_nettype none

module mos_alu (
  input  wire mos_core_pkg::alu_op_e alu_op,
  input  wire mos_isa_pkg::data_t    alu_in,
  input  wire logic                  carry_in,
  output mos_isa_pkg::data_t         alu_out,
  output logic                       carry_out
);

  always_comb begin
    // Safe value for unused encodings
    alu_out   = alu_in;
    carry_out = carry_in;

    case (alu_op)
      // Wraps modulo 256, carry untouched
      mos_core_pkg::INC: alu_out = alu_in + 8'd1;
      mos_core_pkg::DEC: alu_out = alu_in - 8'd1;

      // Old bit 7 lands in carry
      mos_core_pkg::SL: begin
        {carry_out, alu_out} = {alu_in, 1'b0};
      end
      mos_core_pkg::RL: begin
        {carry_out, alu_out} = {alu_in, carry_in};
      end

      // ROR path, old bit 0 lands in carry
      // Only ROR selects SR so carry_in always belongs here
      mos_core_pkg::SR: begin
        {alu_out, carry_out} = {carry_in, alu_in};
      end

      default: begin
        alu_out   = alu_in;
        carry_out = carry_in;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: mos_core.f
mos_isa_pkg.sv
mos_core_pkg.sv
mos_alu.sv
mos_decoder.sv
mos_sequencer.sv
mos_core.sv
tb_clock_gen.sv
tb_mos_core.sv

// File: mos_core.sv
/* Core top: sequencer, decoder and ALU on a single-cycle memory bus
   No back-pressure, rd_data must follow address combinationally */
`timescale 1ns/1ps
`default_nettype none

module mos_core (
  input  wire logic               clk,
  input  wire logic               resetn,
  input  wire mos_isa_pkg::data_t rd_data,
  output mos_isa_pkg::addr_t      address,
  output mos_isa_pkg::data_t      wr_data,
  output logic                    wr_enable
);

  // Sequencer to decoder
  mos_isa_pkg::data_t         opcode;
  mos_core_pkg::instr_class_e instr_class;

  // Decoder straight to ALU
  mos_core_pkg::alu_op_e      alu_op;

  // ALU operand and result
  mos_isa_pkg::data_t         alu_in;
  mos_isa_pkg::data_t         alu_out;
  logic                       carry_in;
  logic                       carry_out;

  mos_sequencer u_sequencer (
    .clk         (clk),
    .resetn      (resetn),
    .rd_data     (rd_data),
    .instr_class (instr_class),
    .alu_out     (alu_out),
    .carry_out   (carry_out),
    .address     (address),
    .wr_data     (wr_data),
    .wr_enable   (wr_enable),
    .opcode      (opcode),
    .alu_in      (alu_in),
    .carry_in    (carry_in)
  );

  mos_decoder u_decoder (
    .opcode      (opcode),
    .instr_class (instr_class),
    .alu_op      (alu_op)
  );

  mos_alu u_alu (
    .alu_op    (alu_op),
    .alu_in    (alu_in),
    .carry_in  (carry_in),
    .alu_out   (alu_out),
    .carry_out (carry_out)
  );

endmodule

`default_nettype wire

// File: mos_core_pkg.sv
/* Sequencer states, ALU operations and instruction classes of the core */
`default_nettype none

package mos_core_pkg;

  localparam int unsigned STATE_W = 4;

  // ------------------------------
  // Sequencer
  // ------------------------------
  typedef enum logic [STATE_W-1:0] {
    RESET,
    VECTOR_1,
    VECTOR_2,
    FETCH,
    DECODE,
    ABS_1,
    ABS_2,
    ABS_3,
    ABS_4,
    HALT
  } state_e;

  // ------------------------------
  // Datapath
  // ------------------------------
  // RL rotates left through carry, SR shifts right with carry into bit 7
  typedef enum logic [2:0] {
    INC,
    DEC,
    SL,
    RL,
    SR
  } alu_op_e;

  typedef enum logic [1:0] {
    IMPLIED,
    JUMP_ABS,
    RMW_ABS,
    ILLEGAL
  } instr_class_e;

endpackage

`default_nettype wire

// File: mos_decoder.sv
/* Purely combinational; any opcode outside the kept subset decodes as ILLEGAL
   alu_op is only meaningful for the RMW class */
`timescale 1ns/1ps
`default_nettype none

module mos_decoder (
  input  wire mos_isa_pkg::data_t            opcode,
  output mos_core_pkg::instr_class_e         instr_class,
  output mos_core_pkg::alu_op_e              alu_op
);

  always_comb begin
    // Defaults cover every unlisted opcode
    instr_class = mos_core_pkg::ILLEGAL;
    alu_op      = mos_core_pkg::INC;

    case (opcode)
      mos_isa_pkg::JMP_abs: instr_class = mos_core_pkg::JUMP_ABS;

      // Memory RMW group
      mos_isa_pkg::ASL_abs: begin
        instr_class = mos_core_pkg::RMW_ABS;
        alu_op      = mos_core_pkg::SL;
      end
      mos_isa_pkg::ROL_abs: begin
        instr_class = mos_core_pkg::RMW_ABS;
        alu_op      = mos_core_pkg::RL;
      end
      // Right shift with carry fed into bit 7
      mos_isa_pkg::ROR_abs: begin
        instr_class = mos_core_pkg::RMW_ABS;
        alu_op      = mos_core_pkg::SR;
      end
      mos_isa_pkg::INC_abs: begin
        instr_class = mos_core_pkg::RMW_ABS;
        alu_op      = mos_core_pkg::INC;
      end
      mos_isa_pkg::DEC_abs: begin
        instr_class = mos_core_pkg::RMW_ABS;
        alu_op      = mos_core_pkg::DEC;
      end

      // Single byte instructions
      mos_isa_pkg::CLC_imp,
      mos_isa_pkg::NOP_imp: instr_class = mos_core_pkg::IMPLIED;

      default: instr_class = mos_core_pkg::ILLEGAL;
    endcase
  end

endmodule

`default_nettype wire

// File: mos_isa_pkg.sv
/* 6502 subset: absolute JMP and read-modify-write, implied CLC and NOP only
   Opcode values are the standard NMOS encodings */
`default_nettype none

package mos_isa_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // ------------------------------
  // Vectors and lengths
  // ------------------------------
  // Reset vector, low byte first
  localparam addr_t RESET_LSB = 16'hFFFC;
  localparam addr_t RESET_MSB = 16'hFFFD;

  // Opcode plus two operand bytes
  localparam addr_t ABS_LEN = 16'd3;

  // ------------------------------
  // Opcodes
  // ------------------------------
  typedef enum logic [DATA_W-1:0] {
    // Absolute jump
    JMP_abs = 8'h4C,
    // Absolute read-modify-write group
    ASL_abs = 8'h0E,
    ROL_abs = 8'h2E,
    ROR_abs = 8'h6E,
    INC_abs = 8'hEE,
    DEC_abs = 8'hCE,
    // Implied, single byte
    CLC_imp = 8'h18,
    NOP_imp = 8'hEA
  } opcode_e;

endpackage

`default_nettype wire

// File: mos_sequencer.sv
/* One instruction at a time; memory must answer reads in the same cycle
   An illegal opcode halts the core until resetn is asserted */
`timescale 1ns/1ps
`default_nettype none

module mos_sequencer (
  input  wire logic                       clk,
  input  wire logic                       resetn,
  input  wire mos_isa_pkg::data_t         rd_data,
  input  wire mos_core_pkg::instr_class_e instr_class,
  input  wire mos_isa_pkg::data_t         alu_out,
  input  wire logic                       carry_out,
  output mos_isa_pkg::addr_t              address,
  output mos_isa_pkg::data_t              wr_data,
  output logic                            wr_enable,
  output mos_isa_pkg::data_t              opcode,
  output mos_isa_pkg::data_t              alu_in,
  output logic                            carry_in
);

  mos_core_pkg::state_e state;
  mos_core_pkg::state_e next_state;

  // Architectural and operand registers
  mos_isa_pkg::addr_t pc;
  mos_isa_pkg::data_t ir;
  mos_isa_pkg::data_t operand_lo;
  mos_isa_pkg::data_t operand_hi;
  logic               carry;

  assign opcode   = ir;
  assign carry_in = carry;

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    next_state = state;
    case (state)
      mos_core_pkg::RESET:    next_state = mos_core_pkg::VECTOR_1;
      mos_core_pkg::VECTOR_1: next_state = mos_core_pkg::VECTOR_2;
      mos_core_pkg::VECTOR_2: next_state = mos_core_pkg::FETCH;
      mos_core_pkg::FETCH:    next_state = mos_core_pkg::DECODE;

      mos_core_pkg::DECODE: begin
        case (instr_class)
          mos_core_pkg::IMPLIED:  next_state = mos_core_pkg::FETCH;
          mos_core_pkg::JUMP_ABS,
          mos_core_pkg::RMW_ABS:  next_state = mos_core_pkg::ABS_1;
          default:                next_state = mos_core_pkg::HALT;
        endcase
      end

      // JMP is done once the high operand byte is in
      mos_core_pkg::ABS_1: begin
        if (instr_class == mos_core_pkg::JUMP_ABS) begin
          next_state = mos_core_pkg::FETCH;
        end else begin
          next_state = mos_core_pkg::ABS_2;
        end
      end

      mos_core_pkg::ABS_2: next_state = mos_core_pkg::ABS_3;
      mos_core_pkg::ABS_3: next_state = mos_core_pkg::ABS_4;
      mos_core_pkg::ABS_4: next_state = mos_core_pkg::FETCH;

      // Stuck until reset
      mos_core_pkg::HALT:  next_state = mos_core_pkg::HALT;
      default:             next_state = mos_core_pkg::HALT;
    endcase
  end

  // ------------------------------
  // Control and bus drive
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= mos_core_pkg::RESET;
      // Vector low byte is presented during reset already
      address   <= mos_isa_pkg::RESET_LSB;
      wr_enable <= 1'b0;
      carry     <= 1'b0;
    end else begin
      state <= next_state;
      case (state)
        mos_core_pkg::VECTOR_1: address <= mos_isa_pkg::RESET_MSB;
        // Vector target becomes the first fetch address
        mos_core_pkg::VECTOR_2: address <= {rd_data, pc[7:0]};
        // Point at the byte after the opcode
        mos_core_pkg::FETCH:    address <= pc + 16'd1;

        mos_core_pkg::DECODE: begin
          case (instr_class)
            mos_core_pkg::IMPLIED: begin
              address <= pc + 16'd1;
              if (ir == mos_isa_pkg::CLC_imp) begin
                carry <= 1'b0;
              end
            end
            // Second operand byte
            mos_core_pkg::JUMP_ABS,
            mos_core_pkg::RMW_ABS: address <= pc + 16'd2;
            // Illegal, address frozen from here on
            default: begin
            end
          endcase
        end

        // Effective address, also the JMP target
        mos_core_pkg::ABS_1: address <= {rd_data, operand_lo};

        // Strobe lands in ABS_4
        mos_core_pkg::ABS_3: begin
          address   <= {operand_hi, operand_lo};
          wr_enable <= 1'b1;
        end

        mos_core_pkg::ABS_4: begin
          wr_enable <= 1'b0;
          address   <= pc + mos_isa_pkg::ABS_LEN;
          // ALU inputs still hold the ABS_3 values
          carry     <= carry_out;
        end

        default: begin
        end
      endcase
    end
  end

  // ------------------------------
  // Datapath registers
  // ------------------------------
  always_ff @(posedge clk) begin
    case (state)
      mos_core_pkg::VECTOR_1: pc[7:0]  <= rd_data;
      mos_core_pkg::VECTOR_2: pc[15:8] <= rd_data;
      mos_core_pkg::FETCH:    ir       <= rd_data;

      mos_core_pkg::DECODE: begin
        operand_lo <= rd_data;
        if (instr_class == mos_core_pkg::IMPLIED) begin
          pc <= pc + 16'd1;
        end
      end

      mos_core_pkg::ABS_1: begin
        operand_hi <= rd_data;
        if (instr_class == mos_core_pkg::JUMP_ABS) begin
          pc <= {rd_data, operand_lo};
        end
      end

      // Memory byte into the ALU, result out one cycle later
      mos_core_pkg::ABS_2: alu_in  <= rd_data;
      mos_core_pkg::ABS_3: wr_data <= alu_out;
      mos_core_pkg::ABS_4: pc      <= pc + mos_isa_pkg::ABS_LEN;

      default: begin
      end
    endcase
  end

  // ------------------------------
  // Checks
  // ------------------------------
  // Write strobe only in the last RMW cycle
  assert property (@(posedge clk) disable iff (!resetn)
    wr_enable |-> (state == mos_core_pkg::ABS_4))
    else $error("wr_enable high outside ABS_4");

  // Halted core keeps the bus still
  assert property (@(posedge clk) disable iff (!resetn)
    (state == mos_core_pkg::HALT) && resetn |=> $stable(address))
    else $error("address moved while halted");

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
/* Free-running 100 ns clock; resetn is held low over the first 2 rising edges */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic resetn
);

  // 50 ns high, 50 ns low
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Release shortly after the second edge
  initial begin
    resetn = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    resetn = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_mos_core.sv
/* Program starts at 0200 and data bytes sit at 0300 and up; 64 KiB memory, same-cycle reads
   Expected writes and fetch addresses come from a small model of the kept 6502 subset */
`timescale 1ns/1ps
`default_nettype none

module tb_mos_core;

  localparam int NROWS       = 11;
  localparam int TIMEOUT     = 20;
  localparam int HALT_WINDOW = 16;
  // Not part of the kept subset
  localparam logic [7:0] ILLEGAL_OP = 8'h02;

  logic        clk;
  logic        resetn;
  logic [15:0] address;
  logic [7:0]  wr_data;
  logic        wr_enable;
  logic [7:0]  rd_data;

  logic [7:0]  mem [0:65535];
  logic [31:0] lfsr_state;
  int unsigned write_count;
  logic [15:0] last_wr_addr;
  logic [7:0]  last_wr_data;
  int unsigned pass_count;
  int unsigned fail_count;

  // Stimulus table and model results, one entry per instruction
  string       row_name    [NROWS];
  logic [7:0]  row_op      [NROWS];
  logic [15:0] row_operand [NROWS];
  logic [7:0]  row_init    [NROWS];
  logic [15:0] row_pc      [NROWS];
  logic [15:0] exp_next    [NROWS];
  logic [7:0]  exp_data    [NROWS];
  bit          has_write   [NROWS];
  logic [15:0] halt_pc;

  tb_clock_gen u_clock_gen (
    .clk    (clk),
    .resetn (resetn)
  );

  mos_core UUT (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable)
  );

  // ------------------------------
  // Memory model
  // ------------------------------
  assign rd_data = mem[address];

  // Write lands on the edge that ends the strobe cycle
  always @(posedge clk) begin
    if (wr_enable === 1'b1) begin
      mem[address] <= wr_data;
      last_wr_addr <= address;
      last_wr_data <= wr_data;
      write_count  <= write_count + 1;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic next_byte(output logic [7:0] value);
    int b;
    value = 8'h00;
    for (b = 0; b < 8; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[6:0], lfsr_state[0]};
    end
  endtask

  task automatic set_row(input int i, input string name, input logic [7:0] op,
                         input logic [15:0] operand);
    row_name[i]    = name;
    row_op[i]      = op;
    row_operand[i] = operand;
  endtask

  // Lays out the program and runs the reference model over the table
  task automatic build_program();
    logic [15:0] pc;
    logic        carry;
    logic [7:0]  b;
    int          i;
    pc    = 16'h0200;
    carry = 1'b0;
    for (i = 0; i < NROWS; i++) begin
      next_byte(b);
      row_init[i]  = b;
      row_pc[i]    = pc;
      has_write[i] = 1'b1;
      mem[pc]      = row_op[i];
      pc           = pc + 16'd3;
      case (row_op[i])
        mos_isa_pkg::INC_abs: exp_data[i] = b + 8'd1;
        mos_isa_pkg::DEC_abs: exp_data[i] = b - 8'd1;
        // Carry takes the bit shifted out
        mos_isa_pkg::ASL_abs: begin
          exp_data[i] = {b[6:0], 1'b0};
          carry       = b[7];
        end
        mos_isa_pkg::ROL_abs: begin
          exp_data[i] = {b[6:0], carry};
          carry       = b[7];
        end
        mos_isa_pkg::ROR_abs: begin
          exp_data[i] = {carry, b[7:1]};
          carry       = b[0];
        end
        mos_isa_pkg::JMP_abs: begin
          has_write[i] = 1'b0;
          pc           = row_operand[i];
        end
        // CLC and NOP, one byte long
        default: begin
          has_write[i] = 1'b0;
          pc           = row_pc[i] + 16'd1;
          if (row_op[i] == mos_isa_pkg::CLC_imp) begin
            carry = 1'b0;
          end
        end
      endcase
      if (pc != row_pc[i] + 16'd1) begin
        mem[row_pc[i] + 16'd1] = row_operand[i][7:0];
        mem[row_pc[i] + 16'd2] = row_operand[i][15:8];
      end
      if (has_write[i]) begin
        mem[row_operand[i]] = row_init[i];
      end
      exp_next[i] = pc;
    end
    halt_pc = pc;
    mem[pc] = ILLEGAL_OP;
  endtask

  // Samples mid-cycle, where the core's outputs are settled
  task automatic wait_address(input logic [15:0] target, input string test, output bit found);
    int cycles;
    found  = 1'b0;
    cycles = 0;
    while (!found && cycles < TIMEOUT) begin
      @(negedge clk);
      found  = (address === target);
      cycles = cycles + 1;
    end
    if (!found) begin
      $display("%s: address never reached %h within %0d cycles", test, target, TIMEOUT);
    end
  endtask

  task automatic finish_test(input string test, input int errors);
    if (errors == 0) begin
      pass_count++;
      $display("PASS %s", test);
    end else begin
      fail_count++;
      $display("FAIL %s (%0d errors)", test, errors);
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    int          i;
    int          errors;
    int unsigned writes_before;
    bit          found;
    lfsr_state  = 32'h3b03811a;
    write_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    // Background pattern over the whole address
    for (i = 0; i < 65536; i++) begin
      mem[i] = i[15:8] ^ i[7:0] ^ 8'hA5;
    end
    mem[mos_isa_pkg::RESET_LSB] = 8'h00;
    mem[mos_isa_pkg::RESET_MSB] = 8'h02;

    set_row(0,  "inc",       mos_isa_pkg::INC_abs, 16'h0300);
    set_row(1,  "dec",       mos_isa_pkg::DEC_abs, 16'h0301);
    set_row(2,  "asl",       mos_isa_pkg::ASL_abs, 16'h0302);
    set_row(3,  "rol_carry", mos_isa_pkg::ROL_abs, 16'h0303);
    set_row(4,  "ror_carry", mos_isa_pkg::ROR_abs, 16'h0304);
    set_row(5,  "clc",       mos_isa_pkg::CLC_imp, 16'h0000);
    set_row(6,  "rol_clc",   mos_isa_pkg::ROL_abs, 16'h0305);
    set_row(7,  "nop",       mos_isa_pkg::NOP_imp, 16'h0000);
    set_row(8,  "jmp",       mos_isa_pkg::JMP_abs, 16'h0240);
    set_row(9,  "inc_far",   mos_isa_pkg::INC_abs, 16'h0306);
    set_row(10, "dec_far",   mos_isa_pkg::DEC_abs, 16'h0307);
    build_program();

    // Reset and vector fetch
    errors = 0;
    i      = 0;
    while (resetn !== 1'b1 && i < TIMEOUT) begin
      @(negedge clk);
      if (resetn !== 1'b1 && wr_enable !== 1'b0) begin
        $display("ERROR reset_vector: expected wr_enable 0, actual %b", wr_enable);
        errors++;
      end
      i++;
    end
    if (resetn !== 1'b1) begin
      $display("reset_vector: resetn was never released");
      errors++;
    end
    repeat (2) @(negedge clk);
    if (address === row_pc[0]) begin
      $display("reset_vector: vector target appeared before the third cycle");
      errors++;
    end
    @(negedge clk);
    if (address !== row_pc[0]) begin
      $display("ERROR reset_vector: expected %h, actual %h", row_pc[0], address);
      errors++;
    end
    finish_test("reset_vector", errors);

    // One instruction per row, done when the next fetch address shows up
    for (i = 0; i < NROWS; i++) begin
      errors        = 0;
      writes_before = write_count;
      wait_address(exp_next[i], row_name[i], found);
      if (!found) begin
        errors++;
      end
      if (has_write[i]) begin
        if (write_count - writes_before != 1) begin
          $display("%s: expected one write strobe, saw %0d", row_name[i],
                   write_count - writes_before);
          errors++;
        end
        if (last_wr_addr !== row_operand[i]) begin
          $display("ERROR %s: expected %h, actual %h", row_name[i], row_operand[i],
                   last_wr_addr);
          errors++;
        end
        if (last_wr_data !== exp_data[i]) begin
          $display("ERROR %s: expected %h, actual %h", row_name[i], exp_data[i], last_wr_data);
          errors++;
        end
      end else if (write_count != writes_before) begin
        $display("%s: memory was written by an instruction that must not write", row_name[i]);
        errors++;
      end
      finish_test(row_name[i], errors);
    end

    // Illegal opcode, bus must freeze on the byte after it
    errors        = 0;
    writes_before = write_count;
    wait_address(halt_pc + 16'd1, "halt", found);
    if (!found) begin
      errors++;
    end
    for (i = 0; i < HALT_WINDOW; i++) begin
      @(negedge clk);
      if (address !== halt_pc + 16'd1) begin
        $display("ERROR halt: expected %h, actual %h", halt_pc + 16'd1, address);
        errors++;
      end
      if (wr_enable !== 1'b0) begin
        $display("ERROR halt: expected wr_enable 0, actual %b", wr_enable);
        errors++;
      end
    end
    if (write_count != writes_before) begin
      $display("halt: memory was written after the illegal opcode");
      errors++;
    end
    finish_test("halt", errors);

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
